//--- line_follower.f
src/motor_pkg.sv
src/sensor_filter.sv
src/pwm_timebase.sv
src/steer_control.sv
src/pwm_channel.sv
src/motor_regs.sv
src/line_follower.sv
verification/tb_line_follower.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_line_follower -f line_follower.f

out=$(./obj_dir/Vtb_line_follower 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'test passed'; then
    exit 0
fi
exit 1

//--- src/line_follower.sv
module line_follower #(
    parameter int PWM_PERIOD = 4000,
    parameter int FILTER_LEN = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [2:0]         sensor,
    input  motor_pkg::wb_req_t wb_in,
    output motor_pkg::wb_rsp_t wb_out,
    output logic               pwm_left,
    output logic               pwm_right
);

    import motor_pkg::*;

    logic [2:0]  pattern;
    logic [11:0] count;
    logic        tick;
    motor_ctrl_t ctrl;
    motor_duty_t manual_duty;
    motor_duty_t duty;

    sensor_filter #(
        .FILTER_LEN(FILTER_LEN)
    ) u_filter (
        .clk    (clk),
        .reset  (reset),
        .sensor (sensor),
        .pattern(pattern)
    );

    pwm_timebase #(
        .PWM_PERIOD(PWM_PERIOD)
    ) u_timebase (
        .clk  (clk),
        .reset(reset),
        .count(count),
        .tick (tick)
    );

    steer_control u_steer (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .pattern    (pattern),
        .ctrl       (ctrl),
        .manual_duty(manual_duty),
        .duty       (duty)
    );

    pwm_channel #(
        .PWM_PERIOD(PWM_PERIOD)
    ) u_pwm_left (
        .clk   (clk),
        .reset (reset),
        .duty  (duty.left),
        .count (count),
        .enable(ctrl.enable),
        .pwm   (pwm_left)
    );

    pwm_channel #(
        .PWM_PERIOD(PWM_PERIOD)
    ) u_pwm_right (
        .clk   (clk),
        .reset (reset),
        .duty  (duty.right),
        .count (count),
        .enable(ctrl.enable),
        .pwm   (pwm_right)
    );

    motor_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_in      (wb_in),
        .wb_out     (wb_out),
        .duty       (duty),
        .pattern    (pattern),
        .ctrl       (ctrl),
        .manual_duty(manual_duty)
    );

endmodule

//--- src/motor_pkg.sv
package motor_pkg;

    typedef logic [9:0] duty_t;

    localparam duty_t DUTY_MAX = 10'd1023;

    typedef struct packed {
        duty_t left;
        duty_t right;
    } motor_duty_t;

    // bit 1 manual, bit 0 enable.
    typedef struct packed {
        logic manual;
        logic enable;
    } motor_ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // sensor patterns, bit 2 is the left sensor; any other code means full speed
    typedef enum logic [2:0] {
        search      = 3'b000,
        hard_right  = 3'b001,
        drift_right = 3'b011,
        hard_left   = 3'b100,
        drift_left  = 3'b110,
        cruise      = 3'b111
    } steer_action_e;

    typedef enum logic [1:0] {
        reg_ctrl   = 2'd0,
        reg_manual = 2'd1,
        reg_status = 2'd2,
        reg_sensor = 2'd3
    } reg_addr_e;

endpackage

//--- src/motor_regs.sv
module motor_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  motor_pkg::wb_req_t     wb_in,
    output motor_pkg::wb_rsp_t     wb_out,
    input  motor_pkg::motor_duty_t duty,
    input  logic [2:0]             pattern,
    output motor_pkg::motor_ctrl_t ctrl,
    output motor_pkg::motor_duty_t manual_duty
);

    import motor_pkg::*;

    reg_addr_e   addr;
    logic        access;   // new cycle, not yet acknowledged.
    logic        ack_q;
    logic [31:0] rdata;
    logic [31:0] rdata_q;

    assign addr   = reg_addr_e'(wb_in.adr);
    assign access = wb_in.cyc && wb_in.stb && !ack_q;

    always_comb begin
        case (addr)
            reg_ctrl:   rdata = {30'b0, ctrl};
            reg_manual: rdata = {6'b0, manual_duty.left, 6'b0, manual_duty.right};
            reg_status: rdata = {6'b0, duty.left, 6'b0, duty.right};
            default:    rdata = {29'b0, pattern};
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;   // one cycle, then drops.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl        <= '0;
            manual_duty <= '0;
        end else if (access && wb_in.we) begin
            case (addr)
                reg_ctrl: begin
                    ctrl <= motor_ctrl_t'(wb_in.dat[1:0]);
                end
                reg_manual: begin
                    manual_duty.left  <= wb_in.dat[25:16];
                    manual_duty.right <= wb_in.dat[9:0];
                end
                default: ;       // status and sensor are read only.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rdata;
        end
    end

    assign wb_out.ack = ack_q;
    assign wb_out.dat = rdata_q;

    // back-to-back cycles must see ack drop in between
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset) wb_out.ack |=> !wb_out.ack
    );

endmodule

//--- src/pwm_channel.sv
module pwm_channel #(
    parameter int PWM_PERIOD = 4000
) (
    input  logic             clk,
    input  logic             reset,
    input  motor_pkg::duty_t duty,
    input  logic [11:0]      count,
    input  logic             enable,
    output logic             pwm
);

    logic [21:0] scaled;    // PWM_PERIOD * duty, fits for periods up to 4096.
    logic [11:0] threshold;

    assign scaled    = 22'(PWM_PERIOD) * {12'b0, duty};
    assign threshold = scaled[21:10];  // divide by 1024, rounded down.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm <= 1'b0;
        end else begin
            pwm <= enable && (count < threshold);
        end
    end

endmodule

//--- src/pwm_timebase.sv
module pwm_timebase #(
    parameter int PWM_PERIOD = 4000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [11:0] count,
    output logic        tick
);

    localparam logic [11:0] LAST = 12'(PWM_PERIOD - 1);

    logic last_cycle;

    assign last_cycle = (count == LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (last_cycle) begin
            count <= '0;            // wrap to start a new period.
        end else begin
            count <= count + 1'b1;
        end
    end

    // the steering update lands on the same edge as the wrap
    assign tick = last_cycle;

endmodule

//--- src/sensor_filter.sv
module sensor_filter #(
    parameter int FILTER_LEN = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] sensor,
    output logic [2:0] pattern
);

    localparam int CNT_W = $clog2(FILTER_LEN + 1);

    logic [2:0]       sync_q1;
    logic [2:0]       sync_q2;
    logic [2:0]       cand;     // value being qualified.
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1 <= 3'b111;
            sync_q2 <= 3'b111;
        end else begin
            sync_q1 <= sensor;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cand       <= 3'b111;
            stable_cnt <= '0;
            pattern    <= 3'b111;
        end else if (sync_q2 != cand) begin
            cand       <= sync_q2;
            stable_cnt <= CNT_W'(1); // this sample is the first of the run.
        end else if (stable_cnt == CNT_W'(FILTER_LEN - 1)) begin
            pattern <= cand;         // FILTER_LEN equal samples seen.
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

//--- src/steer_control.sv
module steer_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tick,
    input  logic [2:0]             pattern,
    input  motor_pkg::motor_ctrl_t ctrl,
    input  motor_pkg::motor_duty_t manual_duty,
    output motor_pkg::motor_duty_t duty
);

    import motor_pkg::*;

    localparam duty_t CRUISE_STEP = 10'd23;
    localparam duty_t HARD_STEP   = 10'd50;
    localparam duty_t FINE_STEP   = 10'd1;

    steer_action_e action;
    motor_duty_t   next_duty;

    function automatic duty_t add_sat(duty_t d, duty_t step);
        logic [10:0] sum;
        sum = {1'b0, d} + {1'b0, step};
        return (sum > {1'b0, DUTY_MAX}) ? DUTY_MAX : sum[9:0];
    endfunction

    function automatic duty_t sub_sat(duty_t d, duty_t step);
        return (d > step) ? d - step : '0;
    endfunction

    assign action = steer_action_e'(pattern);

    always_comb begin
        next_duty = duty;
        case (action)
            cruise: begin
                // anything above 1000 snaps straight to full.
                next_duty.left  = add_sat(duty.left, CRUISE_STEP);
                next_duty.right = add_sat(duty.right, CRUISE_STEP);
            end
            drift_left: begin
                next_duty.left  = sub_sat(duty.left, FINE_STEP);
                next_duty.right = add_sat(duty.right, FINE_STEP);
            end
            hard_left: begin
                next_duty.left  = sub_sat(duty.left, HARD_STEP);
                next_duty.right = sub_sat(duty.right, FINE_STEP);
            end
            drift_right: begin
                next_duty.left  = add_sat(duty.left, FINE_STEP);
                next_duty.right = sub_sat(duty.right, FINE_STEP);
            end
            hard_right: begin
                next_duty.left  = sub_sat(duty.left, FINE_STEP);
                next_duty.right = sub_sat(duty.right, HARD_STEP);
            end
            search: begin
                // spin toward the side that was faster, right wins a tie.
                if (duty.left > duty.right) begin
                    next_duty.left  = DUTY_MAX;
                    next_duty.right = '0;
                end else begin
                    next_duty.left  = '0;
                    next_duty.right = DUTY_MAX;
                end
            end
            default: begin
                next_duty.left  = DUTY_MAX; // full.
                next_duty.right = DUTY_MAX;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty.left  <= DUTY_MAX;
            duty.right <= DUTY_MAX;
        end else if (tick && ctrl.enable) begin
            if (ctrl.manual) begin
                duty <= manual_duty;
            end else begin
                duty <= next_duty;
            end
        end
    end

    // the PWM channels count on duty staying put inside a period
    duty_only_on_tick: assert property (
        @(posedge clk) disable iff (reset) !tick |=> $stable(duty)
    );

endmodule

//--- verification/tb_line_follower.sv
module tb_line_follower;
    timeunit 1ns;
    timeprecision 1ps;

    import motor_pkg::*;

    localparam int PERIOD         = 64;
    localparam int FILTER         = 4;
    localparam int TEST_PERIODS   = 280;  // upper bound on periods used by all tests.
    localparam int TIMEOUT_CYCLES = 2000 + PERIOD * TEST_PERIODS;
    localparam int ACK_LIMIT      = 16;
    localparam int RAMP_GROUPS    = 12;

    logic        clk = 1'b0;
    logic        reset;
    logic [2:0]  sensor;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        pwm_left;
    logic        pwm_right;

    int          cycles = 0;
    int unsigned lcg_state = 92850;

    // reference model state.
    logic [2:0]  cur_pat;
    logic        model_en;
    logic        model_manual;
    int          man_l, man_r, ml, mr;

    line_follower #(.PWM_PERIOD(PERIOD), .FILTER_LEN(FILTER)) dut (
        .clk      (clk),
        .reset    (reset),
        .sensor   (sensor),
        .wb_in    (wb_req),
        .wb_out   (wb_rsp),
        .pwm_left (pwm_left),
        .pwm_right(pwm_right)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) cycles <= 0;
        else cycles <= cycles + 1;
    end

    always @(posedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int clamp_duty(int v);
        if (v < 0) return 0;
        if (v > 1023) return 1023;
        return v;
    endfunction

    function automatic logic [31:0] duty_word(int l, int r);
        return {6'b0, 10'(l), 6'b0, 10'(r)};
    endfunction

    function automatic logic [2:0] ramp_code(int unsigned k);
        case (k)
            0: return 3'b111;
            1: return 3'b110;
            2: return 3'b100;
            3: return 3'b011;
            4: return 3'b001;
            5: return 3'b010;   // full.
            default: return 3'b101;
        endcase
    endfunction

    // steering table applied once per tick.
    function automatic void model_step();
        int l, r;
        if (!model_en) return;
        if (model_manual) begin
            ml = man_l;
            mr = man_r;
            return;
        end
        l = ml;
        r = mr;
        case (cur_pat)
            3'b111: begin
                l = (l > 1000) ? 1023 : l + 23;
                r = (r > 1000) ? 1023 : r + 23;
            end
            3'b110: begin
                l = l - 1;
                r = r + 1;
            end
            3'b100: begin
                l = l - 50;
                r = r - 1;
            end
            3'b011: begin
                l = l + 1;
                r = r - 1;
            end
            3'b001: begin
                l = l - 1;
                r = r - 50;
            end
            3'b000: begin
                if (l > r) begin
                    l = 1023;
                    r = 0;
                end else begin
                    l = 0;
                    r = 1023;
                end
            end
            default: begin
                l = 1023;
                r = 1023;
            end
        endcase
        ml = clamp_duty(l);
        mr = clamp_duty(r);
    endfunction

    task automatic check_equal(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // every wait goes through here so the model sees each tick.
    task automatic step_cycle();
        @(posedge clk);
        #1;
        if (cycles % PERIOD == 0) model_step();
    endtask

    task automatic next_tick();
        step_cycle();
        while (cycles % PERIOD != 0) step_cycle();
    endtask

    task automatic bus_cycle(logic we, logic [1:0] adr, logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
        step_cycle();
        waited = 1;
        while (!wb_rsp.ack) begin
            if (waited >= ACK_LIMIT) begin
                $display("no ack from the bus slave within %0d cycles", ACK_LIMIT);
                $display("test failed");
                $fatal(1, "bus hang");
            end
            step_cycle();
            waited++;
        end
        rdata  = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wb_write(logic [1:0] adr, logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
        if (adr == reg_ctrl) begin
            model_en     = data[0];
            model_manual = data[1];
        end else if (adr == reg_manual) begin
            man_l = int'(data[25:16]);
            man_r = int'(data[9:0]);
        end
    endtask

    task automatic wb_read(logic [1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic check_status();
        logic [31:0] rd;
        wb_read(reg_status, rd);
        check_equal("reg_status", rd, duty_word(ml, mr));
    endtask

    task automatic apply_pattern(logic [2:0] p);
        sensor  = p;
        cur_pat = p;
    endtask

    task automatic measure_width(output int hl, output int hr);
        hl = 0;
        hr = 0;
        repeat (PERIOD) begin
            step_cycle();
            if (pwm_left) hl++;
            if (pwm_right) hr++;
        end
    endtask

    task automatic reset_defaults();
        logic [31:0] rd;
        wb_read(reg_status, rd);
        check_equal("reg_status", rd, 32'h03ff_03ff);
        wb_read(reg_sensor, rd);
        check_equal("reg_sensor", rd, 32'h7);
        wb_read(reg_ctrl, rd);
        check_equal("reg_ctrl", rd, 32'h0);
        next_tick();
        repeat (PERIOD) begin
            step_cycle();
            check_equal("pwm_left", {31'b0, pwm_left}, 32'h0);
            check_equal("pwm_right", {31'b0, pwm_right}, 32'h0);
        end
    endtask

    task automatic register_access();
        logic [31:0] rd;
        wb_write(reg_ctrl, 32'h2);
        wb_read(reg_ctrl, rd);
        check_equal("reg_ctrl", rd, 32'h2);
        wb_write(reg_manual, 32'h0155_00aa);
        wb_read(reg_manual, rd);
        check_equal("reg_manual", rd, 32'h0155_00aa);
        wb_write(reg_status, 32'h0);   // read only.
        check_status();
        wb_write(reg_ctrl, 32'h0);
    endtask

    task automatic steering_ramp();
        int n;
        next_tick();
        apply_pattern(3'b100);
        wb_write(reg_ctrl, 32'h1);
        repeat (22) next_tick();   // left runs down to 0.
        check_status();
        apply_pattern(3'b111);
        repeat (2) next_tick();
        check_status();
        for (int g = 0; g < RAMP_GROUPS; g++) begin
            apply_pattern(ramp_code(next_random() % 7));
            n = 1 + int'(next_random() % 6);
            repeat (n) next_tick();
            check_status();
        end
    endtask

    task automatic search_case(int l, int r, int exp_l, int exp_r);
        logic [31:0] rd;
        wb_write(reg_manual, duty_word(l, r));
        wb_write(reg_ctrl, 32'h3);
        next_tick();
        wb_write(reg_ctrl, 32'h1);
        next_tick();
        wb_read(reg_status, rd);
        check_equal("reg_status", rd, duty_word(exp_l, exp_r));
    endtask

    task automatic search_spin();
        apply_pattern(3'b000);
        search_case(300, 700, 0, 1023);
        search_case(800, 200, 1023, 0);
        search_case(400, 400, 0, 1023);
    endtask

    task automatic pwm_width();
        int hl, hr;
        logic [31:0] rd;
        wb_write(reg_manual, duty_word(512, 100));
        wb_write(reg_ctrl, 32'h3);
        next_tick();
        measure_width(hl, hr);
        check_equal("pwm_left high cycles", hl, PERIOD * 512 / 1024);
        check_equal("pwm_right high cycles", hr, PERIOD * 100 / 1024);
        check_status();
        wb_write(reg_ctrl, 32'h2);
        wb_write(reg_manual, duty_word(5, 900));
        next_tick();
        measure_width(hl, hr);
        check_equal("pwm_left high cycles", hl, 32'h0);
        check_equal("pwm_right high cycles", hr, 32'h0);
        wb_read(reg_status, rd);
        check_equal("reg_status", rd, duty_word(512, 100));
    endtask

    task automatic sensor_debounce();
        logic [31:0] rd;
        sensor = 3'b111;   // short glitch.
        repeat (2) step_cycle();
        sensor = 3'b000;
        repeat (2 + FILTER + 2) begin   // poll through the whole filter window.
            wb_read(reg_sensor, rd);
            check_equal("reg_sensor", rd, 32'h0);
        end
        apply_pattern(3'b110);
        repeat (2 + FILTER) step_cycle();
        wb_read(reg_sensor, rd);
        check_equal("reg_sensor", rd, 32'h6);
    endtask

    initial begin
        reset        = 1'b1;
        sensor       = 3'b111;
        wb_req       = '0;
        cur_pat      = 3'b111;
        model_en     = 1'b0;
        model_manual = 1'b0;
        man_l        = 0;
        man_r        = 0;
        ml           = 1023;
        mr           = 1023;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        reset_defaults();
        register_access();
        steering_ramp();
        search_spin();
        pwm_width();
        sensor_debounce();
        $display("test passed");
        $finish;
    end

endmodule
